// File: all.f
+incdir+hw
+incdir+sim
hw/uart_frame_pkg.sv
hw/uart_fsm_pkg.sv
hw/uart_tick_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_top.sv
sim/tb_uart_top.sv

// File: hw/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

////////////////////////////////////////////////////////////
// Serial timing shared by the tick generator, both
// directions and the testbench.
////////////////////////////////////////////////////////////

// Number of clk cycles between two oversampling ticks.
`define UART_CLKS_PER_TICK 4

// Number of ticks in one bit period.
`define UART_OVERSAMPLE 8

// Data bits in one 8N1 frame.
`define UART_DATA_BITS 8

`endif

// File: hw/uart_frame_pkg.sv
`include "uart_consts.svh"

package uart_frame_pkg;

    // Parallel data byte on both the receive and the transmit side.
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Index of the data bit currently on the line.
    typedef logic [$clog2(`UART_DATA_BITS)-1:0] uart_bit_idx_t;

    // Ticks inside a bit period, with room for one and a half periods.
    typedef logic [$clog2(`UART_OVERSAMPLE + `UART_OVERSAMPLE/2)-1:0] uart_os_cnt_t;

    // clk cycles inside one tick period.
    typedef logic [$clog2(`UART_CLKS_PER_TICK)-1:0] uart_div_cnt_t;

endpackage

// File: hw/uart_fsm_pkg.sv
package uart_fsm_pkg;

    // Receiver. Hunts for a falling edge, moves to the middle of the start
    // bit, then samples data and stop on the centre of each bit.
    typedef enum logic [1:0] {
        rx_find_edge   = 2'd0,
        rx_start_align = 2'd1,
        rx_data_bits   = 2'd2,
        rx_stop_bit    = 2'd3
    } uart_rx_state_t;

    // Transmitter.
    typedef enum logic [1:0] {
        tx_idle      = 2'd0,
        tx_start_bit = 2'd1,
        tx_data_bits = 2'd2,
        tx_stop_bit  = 2'd3
    } uart_tx_state_t;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx
    import uart_frame_pkg::*;
    import uart_fsm_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rx,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    output logic       rx_framing_error
);

    localparam uart_os_cnt_t  half_last = uart_os_cnt_t'(`UART_OVERSAMPLE / 2 - 1);
    localparam uart_os_cnt_t  bit_last  = uart_os_cnt_t'(`UART_OVERSAMPLE - 1);
    localparam uart_bit_idx_t idx_last  = uart_bit_idx_t'(`UART_DATA_BITS - 1);

    uart_rx_state_t state;
    logic           prev_rx;
    uart_bit_idx_t  bit_idx;
    uart_os_cnt_t   os_cnt;
    uart_byte_t     shift_reg;
    logic           sample;

    // High on the tick at the centre of a data bit.
    assign sample = tick && (state == rx_data_bits) && (os_cnt == bit_last);

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_reg[bit_idx] <= rx; // LSB arrives first.
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= rx_find_edge;
            prev_rx          <= 1'b1; // The line idles at the mark level.
            bit_idx          <= '0;
            os_cnt           <= '0;
            rx_data          <= '0;
            rx_valid         <= 1'b0;
            rx_framing_error <= 1'b0;
        end else begin
            rx_valid         <= 1'b0;
            rx_framing_error <= 1'b0;
            if (tick) begin
                case (state)
                    rx_find_edge: begin
                        prev_rx <= rx;
                        if (prev_rx && !rx) begin
                            state  <= rx_start_align;
                            os_cnt <= '0;
                        end
                    end
                    rx_start_align: begin
                        // Half a bit puts every later sample at a bit centre.
                        if (os_cnt == half_last) begin
                            os_cnt  <= '0;
                            bit_idx <= '0;
                            state   <= rx_data_bits;
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                    rx_data_bits: begin
                        if (os_cnt == bit_last) begin
                            os_cnt <= '0;
                            if (bit_idx == idx_last) begin
                                state <= rx_stop_bit;
                            end else begin
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                    rx_stop_bit: begin
                        if (os_cnt == bit_last) begin
                            os_cnt  <= '0;
                            prev_rx <= rx; // A low stop must go high again before the next edge.
                            state   <= rx_find_edge;
                            if (rx) begin
                                rx_valid <= 1'b1;
                                rx_data  <= shift_reg;
                            end else begin
                                rx_framing_error <= 1'b1;
                            end
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                    default: state <= rx_find_edge;
                endcase
            end
        end
    end

    // Each frame ends in exactly one outcome, reported as a single pulse.
    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        !(rx_valid && rx_framing_error));
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);
    a_error_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_framing_error |=> !rx_framing_error);

endmodule

// File: hw/uart_tick_gen.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tick_gen
    import uart_frame_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam uart_div_cnt_t div_last = uart_div_cnt_t'(`UART_CLKS_PER_TICK - 1);

    uart_div_cnt_t div_cnt;

    ////////////////////////////////////////////////////////////
    // Modulo divider. Both directions run on this phase, so the
    // receiver's sampling grid is fixed relative to tx.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == div_last) begin
            div_cnt <= '0;
            tick    <= 1'b1; // Registered, so the first tick lands a full period after reset.
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

// File: hw/uart_top.sv
`timescale 1ns/1ps

module uart_top
    import uart_frame_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    input  logic       tx_start,
    input  uart_byte_t tx_data,
    output logic       tx,
    output logic       tx_busy,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    output logic       rx_framing_error
);

    logic tick; // Shared oversampling strobe.

    ////////////////////////////////////////////////////////////
    // One tick source for both directions
    ////////////////////////////////////////////////////////////

    uart_tick_gen u_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_rx (
        .clk              (clk),
        .rst              (rst),
        .tick             (tick),
        .rx               (rx),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .rx_framing_error (rx_framing_error)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx
    import uart_frame_pkg::*;
    import uart_fsm_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       tx_start,
    input  uart_byte_t tx_data,
    output logic       tx,
    output logic       tx_busy
);

    localparam uart_os_cnt_t  bit_last = uart_os_cnt_t'(`UART_OVERSAMPLE - 1);
    localparam uart_bit_idx_t idx_last = uart_bit_idx_t'(`UART_DATA_BITS - 1);

    uart_tx_state_t state;
    uart_byte_t     shift_reg;
    uart_bit_idx_t  bit_idx;
    uart_os_cnt_t   os_cnt;
    logic           accept;
    logic           bit_end;

    assign accept  = tx_start && !tx_busy; // Starts while busy are dropped.
    assign bit_end = tick && (os_cnt == bit_last);

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= tx_data;
        end else if (bit_end && (state == tx_start_bit || state == tx_data_bits)) begin
            shift_reg <= shift_reg >> 1; // Next bit to send sits in bit 0.
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    // Idle with tx_busy high means a byte is waiting for the next tick.
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= tx_idle;
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            bit_idx <= '0;
            os_cnt  <= '0;
        end else begin
            case (state)
                tx_idle: begin
                    if (accept) begin
                        tx_busy <= 1'b1;
                    end else if (tx_busy && tick) begin
                        state  <= tx_start_bit;
                        tx     <= 1'b0;
                        os_cnt <= '0;
                    end
                end
                tx_start_bit: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                        state   <= tx_data_bits;
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                tx_data_bits: begin
                    if (bit_end) begin
                        os_cnt <= '0;
                        if (bit_idx == idx_last) begin
                            tx    <= 1'b1;
                            state <= tx_stop_bit;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[0];
                        end
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                tx_stop_bit: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        tx_busy <= 1'b0;
                        state   <= tx_idle;
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // The line only leaves the mark level inside a frame.
    a_idle_mark: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx);

endmodule

// File: sim/tb_uart_checks.svh
`ifndef TB_UART_CHECKS_SVH
`define TB_UART_CHECKS_SVH

// Totals for the closing report.
int checks_run = 0;
int errors     = 0;

task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    checks_run++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks_run++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic report_timeout(input string what);
    errors++;
    $display("Timeout at %0t: %s never came within 12 bit periods", $time, what);
endtask

`endif

// File: sim/tb_uart_top.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uart_top
    import uart_frame_pkg::*;
();

    localparam int bit_clks       = `UART_CLKS_PER_TICK * `UART_OVERSAMPLE;
    localparam int timeout_cycles = 12 * bit_clks;
    localparam int frame_bits     = `UART_DATA_BITS + 2;

    logic       clk;
    logic       rst;
    logic       rx;
    logic       rx_drv;
    logic       loop_en;   // Routes tx back into rx.
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx;
    logic       tx_busy;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_framing_error;

    uart_byte_t exp_byte_q[$];
    logic       exp_ok_q[$];
    int         n_expected = 0;
    int         outcomes   = 0;

    `include "tb_uart_checks.svh"

    assign rx = loop_en ? tx : rx_drv;

    uart_top u_uart_top (
        .clk              (clk),
        .rst              (rst),
        .rx               (rx),
        .tx_start         (tx_start),
        .tx_data          (tx_data),
        .tx               (tx),
        .tx_busy          (tx_busy),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .rx_framing_error (rx_framing_error)
    );

    always #10 clk = ~clk;

    // Expected line levels, bit 0 first, and the receiver outcome for them.
    function automatic logic [frame_bits-1:0] ref_frame(input uart_byte_t data,
            input logic bad_stop, output uart_byte_t exp_byte, output logic exp_ok);
        logic [frame_bits-1:0] frame;
        int i;
        frame[0] = 1'b0;
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            frame[i + 1] = data[i]; // LSB follows the start bit.
        end
        frame[frame_bits-1] = !bad_stop;
        exp_byte = data;
        exp_ok   = !bad_stop;
        return frame;
    endfunction

    ////////////////////////////////////////////////////////////
    // Receiver outcomes are matched against the expected queue.
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && (rx_valid || rx_framing_error)) begin
            outcomes++;
            if (exp_ok_q.size() == 0) begin
                errors++;
                $display("Error at %0t: receiver pulse with no frame on the line", $time);
            end else begin
                check_bit("rx_valid", rx_valid, exp_ok_q[0]);
                check_bit("rx_framing_error", rx_framing_error, !exp_ok_q[0]);
                if (exp_ok_q[0])
                    check_byte("rx_data", rx_data, exp_byte_q[0]);
                void'(exp_ok_q.pop_front());
                void'(exp_byte_q.pop_front());
            end
        end
    end

    task automatic expect_rx(input uart_byte_t data, input logic bad_stop);
        uart_byte_t eb;
        logic       ok;
        void'(ref_frame(data, bad_stop, eb, ok));
        exp_byte_q.push_back(eb);
        exp_ok_q.push_back(ok);
        n_expected++;
    endtask

    task automatic wait_outcomes(input string what);
        int t;
        t = 0;
        while (outcomes < n_expected && t < timeout_cycles) begin
            @(posedge clk);
            t++;
        end
        if (outcomes < n_expected) report_timeout(what);
    endtask

    // Waits on tx_busy, or on tx when on_line is set.
    task automatic wait_tx(input bit on_line, input logic level, input string what);
        int t;
        t = 0;
        while ((on_line ? tx : tx_busy) !== level && t < timeout_cycles) begin
            @(negedge clk);
            t++;
        end
        if ((on_line ? tx : tx_busy) !== level) report_timeout(what);
    endtask

    task automatic receive_one(input uart_byte_t data, input logic bad_stop);
        logic [frame_bits-1:0] frame;
        uart_byte_t            eb;
        logic                  ok;
        int                    i;
        frame = ref_frame(data, bad_stop, eb, ok);
        expect_rx(data, bad_stop);
        @(negedge clk);
        for (i = 0; i < frame_bits; i++) begin
            rx_drv = frame[i];
            repeat (bit_clks) @(negedge clk);
        end
        rx_drv = 1'b1; // One idle bit so a low stop can recover.
        repeat (bit_clks) @(negedge clk);
        wait_outcomes("rx_valid or rx_framing_error");
    endtask

    task automatic start_tx(input uart_byte_t data);
        @(negedge clk);
        tx_data  = data;
        tx_start = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
    endtask

    // Sends one byte and recovers it from the centre of each bit on tx.
    task automatic tx_check(input uart_byte_t data);
        logic [frame_bits-1:0] exp_frame;
        logic [frame_bits-1:0] got;
        uart_byte_t            eb;
        logic                  ok;
        int                    i;
        exp_frame = ref_frame(data, 1'b0, eb, ok);
        start_tx(data);
        wait_tx(1'b0, 1'b1, "tx_busy rise");
        wait_tx(1'b1, 1'b0, "tx start bit edge");
        repeat (bit_clks / 2) @(negedge clk);
        for (i = 0; i < frame_bits; i++) begin
            got[i] = tx;
            check_bit("tx_busy", tx_busy, 1'b1);
            if (i < frame_bits - 1)
                repeat (bit_clks) @(negedge clk);
        end
        check_bit("tx start bit", got[0], exp_frame[0]);
        check_byte("tx data", got[frame_bits-2:1], eb);
        check_bit("tx stop bit", got[frame_bits-1], exp_frame[frame_bits-1]);
        wait_tx(1'b0, 1'b0, "tx_busy fall");
        check_bit("tx", tx, 1'b1);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before)
            $display("Test %s: passed", name);
        else
            $display("Test %s: failed with %0d errors", name, errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int         seed;
        int         err0;
        int         i;
        logic       extra;
        uart_byte_t d;
        clk      = 1'b0;
        rst      = 1'b1;
        rx_drv   = 1'b1;
        loop_en  = 1'b0;
        tx_start = 1'b0;
        tx_data  = '0;
        seed     = 57;
        void'($urandom(seed));
        repeat (8) @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        @(negedge clk);
        check_bit("tx", tx, 1'b1);
        check_bit("tx_busy", tx_busy, 1'b0);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("rx_framing_error", rx_framing_error, 1'b0);
        check_byte("rx_data", rx_data, '0);
        end_test("reset state", err0);

        err0 = errors;
        for (i = 0; i < 20; i++)
            receive_one(uart_byte_t'($urandom), 1'b0);
        end_test("receive", err0);

        err0 = errors;
        receive_one(uart_byte_t'($urandom), 1'b1);
        receive_one(uart_byte_t'($urandom), 1'b0);
        end_test("framing error", err0);

        err0 = errors;
        for (i = 0; i < 8; i++)
            tx_check(uart_byte_t'($urandom));
        end_test("transmit", err0);

        err0 = errors;
        d = uart_byte_t'($urandom);
        fork
            tx_check(d);
            begin
                repeat (3 * bit_clks) @(negedge clk);
                tx_data  = ~d;
                tx_start = 1'b1; // Lands in the middle of the frame.
                @(negedge clk);
                tx_start = 1'b0;
            end
        join
        extra = 1'b0;
        repeat (2 * bit_clks) begin
            @(negedge clk);
            if (tx_busy || !tx)
                extra = 1'b1;
        end
        check_bit("tx_busy or low tx after ignored start", extra, 1'b0);
        end_test("busy ignore", err0);

        err0 = errors;
        loop_en = 1'b1;
        for (i = 0; i < 10; i++) begin
            d = uart_byte_t'($urandom);
            expect_rx(d, 1'b0);
            start_tx(d);
            wait_outcomes("loopback rx_valid");
            wait_tx(1'b0, 1'b0, "tx_busy fall");
        end
        end_test("loopback", err0);

        $display("Checks run: %0d, errors: %0d", checks_run, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
